/* rtl/cache_pkg.sv */
package cache_pkg;

   localparam int addr_bits   = 12;
   localparam int word_bits   = 32;
   localparam int line_words  = 4;
   localparam int line_bits   = word_bits * line_words;
   localparam int offset_bits = 4;                           // byte offset within a line
   localparam int index_bits  = 4;
   localparam int cache_lines = 1 << index_bits;
   localparam int tag_bits    = addr_bits - index_bits - offset_bits;
   localparam int mem_words   = 1024;                        // 4 KiB behind the cache

   typedef logic [addr_bits-1:0]          addr_t;
   typedef logic [word_bits-1:0]          word_t;
   typedef logic [line_bits-1:0]          line_t;
   typedef logic [tag_bits-1:0]           tag_t;
   typedef logic [index_bits-1:0]         index_t;
   typedef logic [$clog2(line_words)-1:0] beat_t;
   typedef logic [15:0]                   count_t;

   typedef struct packed {
      logic  valid;
      logic  write;
      logic  size_word;                                      // 1 for a word and 0 for a byte
      addr_t addr;
      word_t wdata;
   } cpu_req_t;

   typedef struct packed {
      logic  start;
      logic  write_back;
      addr_t line_addr;                                      // low offset bits are zero
      line_t data;
   } line_req_t;

   typedef struct packed {
      logic  done;
      line_t data;
   } line_rsp_t;

   typedef struct packed {
      logic  cyc;
      logic  stb;
      logic  we;
      addr_t adr;
      word_t dat;
   } wb_m_t;

   typedef struct packed {
      logic  ack;
      word_t dat;
   } wb_s_t;

   typedef struct packed {
      logic hit;
      logic miss;
      logic write_back;
      logic flush_done;
   } event_t;

   typedef enum logic [1:0] {core_idle, core_write_back, core_fill, core_flush} core_state_e;
   typedef enum logic [1:0] {master_idle, master_strobe, master_next} master_state_e;

endpackage

/* rtl/cache_core.sv */
`timescale 1ns/1ns

module cache_core (
   input  logic                 clock,
   input  logic                 arst_n,
   input  cache_pkg::cpu_req_t  req,
   output cache_pkg::word_t     rdata,
   output logic                 ready,
   output cache_pkg::line_req_t line_req,
   input  cache_pkg::line_rsp_t line_rsp,
   input  logic                 flush_req,
   output cache_pkg::event_t    events
);

   cache_pkg::tag_t                   tags [cache_pkg::cache_lines];
   cache_pkg::line_t                  lines [cache_pkg::cache_lines];
   logic [cache_pkg::cache_lines-1:0] valid;
   logic [cache_pkg::cache_lines-1:0] dirty;

   cache_pkg::core_state_e state;
   cache_pkg::index_t      flush_index;
   logic                   flush_pending;                    // request seen but walk not started
   logic                   flush_active;
   logic                   missed;                           // current request already counted a miss
   logic                   start_q;

   cache_pkg::tag_t   req_tag;
   cache_pkg::index_t req_index;
   cache_pkg::beat_t  req_word;
   logic [1:0]        req_byte;
   cache_pkg::index_t cur_index;
   cache_pkg::word_t  hit_word;
   logic              hit;
   logic              accept;
   logic              miss_start;
   logic              flush_last;

   assign req_tag   = req.addr[cache_pkg::addr_bits-1 -: cache_pkg::tag_bits];
   assign req_index = req.addr[cache_pkg::offset_bits +: cache_pkg::index_bits];
   assign req_word  = req.addr[3:2];
   assign req_byte  = req.addr[1:0];
   assign cur_index = flush_active ? flush_index : req_index;  // the flush walk owns the index

   assign hit      = valid[req_index] && (tags[req_index] == req_tag);
   assign ready    = !req.valid || (state == cache_pkg::core_idle && hit);
   assign accept   = req.valid && ready;
   assign hit_word = lines[req_index][32*req_word +: 32];
   assign rdata    = req.size_word ? hit_word : {24'b0, hit_word[8*req_byte +: 8]};

   assign miss_start = state == cache_pkg::core_idle && !flush_pending && req.valid && !hit;
   assign flush_last = state == cache_pkg::core_flush && !(valid[flush_index] && dirty[flush_index])
                       && flush_index == '1;

   always_comb begin
      events.hit        = accept && !missed;                   // a refilled request is not a hit
      events.miss       = miss_start;
      events.write_back = start_q && state == cache_pkg::core_write_back;
      events.flush_done = flush_last;
   end

   // the line master latches these fields on the start pulse
   always_comb begin
      line_req.start      = start_q;
      line_req.write_back = state == cache_pkg::core_write_back;
      if (line_req.write_back) begin
         line_req.line_addr = {tags[cur_index], cur_index, 4'b0};
      end else begin
         line_req.line_addr = {req_tag, req_index, 4'b0};
      end
      line_req.data = lines[cur_index];
   end

   always_ff @(posedge clock or negedge arst_n) begin
      if (!arst_n) begin
         state         <= cache_pkg::core_idle;
         flush_index   <= '0;
         flush_pending <= 1'b0;
         flush_active  <= 1'b0;
         missed        <= 1'b0;
         start_q       <= 1'b0;
         valid         <= '0;
         dirty         <= '0;
      end else begin
         start_q <= 1'b0;
         if (flush_req) flush_pending <= 1'b1;
         if (accept) missed <= 1'b0;
         case (state)
            cache_pkg::core_idle: begin
               if (flush_pending) begin
                  state         <= cache_pkg::core_flush;
                  flush_pending <= 1'b0;
                  flush_active  <= 1'b1;
                  flush_index   <= '0;
               end else if (miss_start) begin
                  missed  <= 1'b1;
                  start_q <= 1'b1;
                  // a valid line that misses holds another tag
                  if (valid[req_index] && dirty[req_index]) begin
                     state <= cache_pkg::core_write_back;
                  end else begin
                     state <= cache_pkg::core_fill;
                  end
               end
            end
            cache_pkg::core_write_back: begin
               if (line_rsp.done) begin
                  dirty[cur_index] <= 1'b0;
                  if (flush_active) begin
                     state <= cache_pkg::core_flush;         // recheck this index and move on
                  end else begin
                     state   <= cache_pkg::core_fill;
                     start_q <= 1'b1;
                  end
               end
            end
            cache_pkg::core_fill: begin
               if (line_rsp.done) begin
                  valid[req_index] <= 1'b1;
                  dirty[req_index] <= 1'b0;
                  state            <= cache_pkg::core_idle;
               end
            end
            cache_pkg::core_flush: begin
               if (valid[flush_index] && dirty[flush_index]) begin
                  state   <= cache_pkg::core_write_back;
                  start_q <= 1'b1;
               end else if (flush_last) begin
                  valid        <= '0;
                  dirty        <= '0;
                  flush_active <= 1'b0;
                  state        <= cache_pkg::core_idle;
               end else begin
                  flush_index <= flush_index + 1'b1;
               end
            end
            default: state <= cache_pkg::core_idle;
         endcase
         if (accept && req.write) dirty[req_index] <= 1'b1;
      end
   end

   always_ff @(posedge clock) begin
      if (state == cache_pkg::core_fill && line_rsp.done) begin
         lines[req_index] <= line_rsp.data;
         tags[req_index]  <= req_tag;
      end else if (accept && req.write) begin
         if (req.size_word) begin
            lines[req_index][32*req_word +: 32] <= req.wdata;
         end else begin
            lines[req_index][8*req.addr[3:0] +: 8] <= req.wdata[7:0];
         end
      end
   end

endmodule

/* rtl/wb_line_master.sv */
`timescale 1ns/1ns

module wb_line_master (
   input  logic                 clock,
   input  logic                 arst_n,
   input  cache_pkg::line_req_t line_req,
   output cache_pkg::line_rsp_t line_rsp,
   output cache_pkg::wb_m_t     wb_out,
   input  cache_pkg::wb_s_t     wb_in
);

   localparam int line_no_bits = cache_pkg::addr_bits - cache_pkg::offset_bits;

   cache_pkg::master_state_e state;
   cache_pkg::beat_t         beat;
   logic                     done_q;
   logic [line_no_bits-1:0]  line_no;                        // line number of the transfer
   logic                     we_q;
   cache_pkg::line_t         line_q;                         // outgoing line or assembled fill

   always_ff @(posedge clock or negedge arst_n) begin
      if (!arst_n) begin
         state  <= cache_pkg::master_idle;
         beat   <= '0;
         done_q <= 1'b0;
      end else begin
         done_q <= 1'b0;
         case (state)
            cache_pkg::master_idle: begin
               if (line_req.start) begin
                  state <= cache_pkg::master_strobe;
                  beat  <= '0;
               end
            end
            cache_pkg::master_strobe: begin
               if (wb_in.ack) begin
                  if (beat == '1) begin
                     state  <= cache_pkg::master_idle;
                     done_q <= 1'b1;
                  end else begin
                     state <= cache_pkg::master_next;
                  end
               end
            end
            cache_pkg::master_next: begin
               beat  <= beat + 1'b1;                         // stb is low for this one cycle
               state <= cache_pkg::master_strobe;
            end
            default: state <= cache_pkg::master_idle;
         endcase
      end
   end

   always_ff @(posedge clock) begin
      if (state == cache_pkg::master_idle && line_req.start) begin
         line_no <= line_req.line_addr[cache_pkg::addr_bits-1:cache_pkg::offset_bits];
         we_q    <= line_req.write_back;
         line_q  <= line_req.data;
      end else if (state == cache_pkg::master_strobe && wb_in.ack && !we_q) begin
         line_q[32*beat +: 32] <= wb_in.dat;
      end
   end

   always_comb begin
      wb_out.cyc = state != cache_pkg::master_idle;
      wb_out.stb = state == cache_pkg::master_strobe;
      wb_out.we  = we_q && wb_out.cyc;
      wb_out.adr = {line_no, beat, 2'b00};
      wb_out.dat = line_q[32*beat +: 32];
   end

   assign line_rsp.done = done_q;
   assign line_rsp.data = line_q;

endmodule

/* rtl/line_memory.sv */
`timescale 1ns/1ns

module line_memory (
   input  logic             clock,
   input  logic             arst_n,
   input  cache_pkg::wb_m_t wb_in,
   output cache_pkg::wb_s_t wb_out
);

   localparam int word_addr_bits = $clog2(cache_pkg::mem_words);

   cache_pkg::word_t          mem [cache_pkg::mem_words];
   logic                      ack_q;
   cache_pkg::word_t          dat_q;
   logic                      access;
   logic [word_addr_bits-1:0] word_addr;

   assign word_addr = wb_in.adr[cache_pkg::addr_bits-1:2];
   assign access    = wb_in.cyc && wb_in.stb && !ack_q;     // one ack per strobe

   // every word starts out holding a pattern plus its own word address
   initial begin
      for (int w = 0; w < cache_pkg::mem_words; w++) begin
         mem[w] = 32'hC0DE0000 + w;
      end
   end

   always_ff @(posedge clock or negedge arst_n) begin
      if (!arst_n) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= access;
      end
   end

   always @(posedge clock) begin
      if (access) begin
         if (wb_in.we) begin
            mem[word_addr] <= wb_in.dat;
         end
         dat_q <= mem[word_addr];                            // old contents on a write
      end
   end

   assign wb_out.ack = ack_q;
   assign wb_out.dat = dat_q;

endmodule

/* rtl/cache_regs.sv */
`timescale 1ns/1ns

module cache_regs (
   input  logic              clock,
   input  logic              arst_n,
   input  cache_pkg::wb_m_t  wb_in,
   output cache_pkg::wb_s_t  wb_out,
   input  cache_pkg::event_t events,
   output logic              flush_req
);

   logic              ack_q;
   logic              flush_q;
   logic              busy_q;
   cache_pkg::word_t  dat_q;
   cache_pkg::count_t hit_count;
   cache_pkg::count_t miss_count;
   cache_pkg::count_t wb_count;
   logic [1:0]        reg_sel;
   logic              access;
   logic              flush_write;

   assign reg_sel     = wb_in.adr[3:2];                      // word offset in the register block
   assign access      = wb_in.cyc && wb_in.stb && !ack_q;
   assign flush_write = access && wb_in.we && reg_sel == 2'd0 && wb_in.dat[0];

   always_ff @(posedge clock or negedge arst_n) begin
      if (!arst_n) begin
         ack_q      <= 1'b0;
         flush_q    <= 1'b0;
         busy_q     <= 1'b0;
         hit_count  <= '0;
         miss_count <= '0;
         wb_count   <= '0;
      end else begin
         ack_q   <= access;
         flush_q <= flush_write;
         if (flush_write) begin
            busy_q <= 1'b1;
         end else if (events.flush_done) begin
            busy_q <= 1'b0;
         end
         if (events.hit) hit_count <= hit_count + 1'b1;
         if (events.miss) miss_count <= miss_count + 1'b1;
         if (events.write_back) wb_count <= wb_count + 1'b1;
      end
   end

   always_ff @(posedge clock) begin
      if (access) begin
         case (reg_sel)
            2'd0:    dat_q <= {30'b0, busy_q, 1'b0};
            2'd1:    dat_q <= cache_pkg::word_t'(hit_count);
            2'd2:    dat_q <= cache_pkg::word_t'(miss_count);
            default: dat_q <= cache_pkg::word_t'(wb_count);
         endcase
      end
   end

   assign wb_out.ack = ack_q;
   assign wb_out.dat = dat_q;
   assign flush_req  = flush_q;

endmodule

/* rtl/cache_top.sv */
`timescale 1ns/1ns

module cache_top (
   input  logic                clock,
   input  logic                arst_n,
   input  cache_pkg::cpu_req_t req,
   output cache_pkg::word_t    rdata,
   output logic                ready,
   input  cache_pkg::wb_m_t    reg_wb_in,
   output cache_pkg::wb_s_t    reg_wb_out
);

   cache_pkg::line_req_t line_req;
   cache_pkg::line_rsp_t line_rsp;
   cache_pkg::wb_m_t     mem_wb_m;                           // line master to backing memory
   cache_pkg::wb_s_t     mem_wb_s;
   cache_pkg::event_t    events;
   logic                 flush_req;

   cache_core core0 (
      .clock     (clock),
      .arst_n    (arst_n),
      .req       (req),
      .rdata     (rdata),
      .ready     (ready),
      .line_req  (line_req),
      .line_rsp  (line_rsp),
      .flush_req (flush_req),
      .events    (events)
   );

   wb_line_master master0 (
      .clock    (clock),
      .arst_n   (arst_n),
      .line_req (line_req),
      .line_rsp (line_rsp),
      .wb_out   (mem_wb_m),
      .wb_in    (mem_wb_s)
   );

   line_memory mem0 (
      .clock  (clock),
      .arst_n (arst_n),
      .wb_in  (mem_wb_m),
      .wb_out (mem_wb_s)
   );

   cache_regs regs0 (
      .clock     (clock),
      .arst_n    (arst_n),
      .wb_in     (reg_wb_in),
      .wb_out    (reg_wb_out),
      .events    (events),
      .flush_req (flush_req)
   );

endmodule

/* tests/cache_properties.sv */
`timescale 1ns/1ns

module cache_properties (
   input logic clock,
   input logic arst_n,
   input logic req_valid,
   input logic ready,
   input logic start,
   input logic cyc,
   input logic stb,
   input logic ack
);

   ready_when_idle: assert property (@(posedge clock) disable iff (!arst_n) !req_valid |-> ready)
      else $error("ready is low although no request is valid");

   strobe_in_cycle: assert property (@(posedge clock) disable iff (!arst_n) stb |-> cyc)
      else $error("stb is high outside a bus cycle");

   ack_with_strobe: assert property (@(posedge clock) disable iff (!arst_n) ack |-> stb)
      else $error("ack arrived without stb");

   start_pulse: assert property (@(posedge clock) disable iff (!arst_n) start |=> !start)
      else $error("line request start lasted more than one cycle");

endmodule

// the core has no memory bus, so its bus inputs are tied off
bind cache_core cache_properties core_checks (
   .clock     (clock),
   .arst_n    (arst_n),
   .req_valid (req.valid),
   .ready     (ready),
   .start     (line_req.start),
   .cyc       (1'b0),
   .stb       (1'b0),
   .ack       (1'b0)
);

bind wb_line_master cache_properties master_checks (
   .clock     (clock),
   .arst_n    (arst_n),
   .req_valid (1'b0),
   .ready     (1'b1),
   .start     (line_req.start),
   .cyc       (wb_out.cyc),
   .stb       (wb_out.stb),
   .ack       (wb_in.ack)
);

/* tests/cache_tb.sv */
`timescale 1ns/1ns

module cache_tb;

   typedef enum logic [2:0] {op_read, op_write, op_reg_read, op_reg_write, op_wait_idle} op_e;

   typedef struct packed {
      op_e              op;
      logic             size_word;
      cache_pkg::addr_t addr;                                // register offset sits in bits 3:2
      cache_pkg::word_t wdata;
      logic             has_exp;
      cache_pkg::word_t exp;
   } entry_t;

   logic                clock;
   logic                arst_n;
   cache_pkg::cpu_req_t req;
   cache_pkg::word_t    rdata;
   logic                ready;
   cache_pkg::wb_m_t    reg_m;
   cache_pkg::wb_s_t    reg_s;

   entry_t                            stimulus [$];
   cache_pkg::word_t                  shadow [cache_pkg::mem_words];
   cache_pkg::tag_t                   m_tag [cache_pkg::cache_lines];
   logic [cache_pkg::cache_lines-1:0] m_valid;
   logic [cache_pkg::cache_lines-1:0] m_dirty;
   int unsigned                       hits;
   int unsigned                       misses;
   int unsigned                       write_backs;
   logic [31:0]                       lfsr_state;
   int unsigned                       limit_cycles = 0;

   cache_top dut0 (
      .clock      (clock),
      .arst_n     (arst_n),
      .req        (req),
      .rdata      (rdata),
      .ready      (ready),
      .reg_wb_in  (reg_m),
      .reg_wb_out (reg_s)
   );

   always #5 clock = ~clock;

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
   endfunction

   task automatic take_bits(input int n, output logic [31:0] value);
      value = '0;
      for (int k = 0; k < n; k++) begin
         lfsr_state = lfsr_next(lfsr_state);
         value      = {value[30:0], lfsr_state[0]};
      end
   endtask

   task automatic check_value(input string name, input cache_pkg::word_t actual,
                              input cache_pkg::word_t expected);
      if (actual !== expected) begin
         $display("Fail %s: got 0x%h, expected 0x%h", name, actual, expected);
         $display("TB FAILED");
         $fatal(1, "mismatch on %s", name);
      end
   endtask

   task automatic add_entry(input op_e op, input logic size_word, input cache_pkg::addr_t addr,
                            input cache_pkg::word_t wdata, input logic has_exp,
                            input cache_pkg::word_t exp);
      stimulus.push_back('{op, size_word, addr, wdata, has_exp, exp});
   endtask

   task automatic add_random(input int count);
      logic [31:0] bits;
      logic [31:0] data;
      for (int n = 0; n < count; n++) begin
         take_bits(11, bits);                                // write, size, tag, index, word, byte
         take_bits(32, data);
         add_entry(bits[10] ? op_write : op_read, bits[9],
                   {2'b00, bits[8:7], 1'b0, bits[6:4], bits[3:2], bits[9] ? 2'b00 : bits[1:0]},
                   data, 1'b0, '0);
      end
   endtask

   // reference model of a direct-mapped write-back cache over the shadow memory
   task automatic model_access(input entry_t e, output cache_pkg::word_t value);
      int                w;
      int                b;
      cache_pkg::index_t i;
      cache_pkg::tag_t   t;
      w = e.addr >> 2;
      b = e.addr[1:0];
      i = e.addr[cache_pkg::offset_bits +: cache_pkg::index_bits];
      t = e.addr[cache_pkg::addr_bits-1 -: cache_pkg::tag_bits];
      if (m_valid[i] && m_tag[i] == t) begin
         hits++;
      end else begin
         misses++;
         if (m_valid[i] && m_dirty[i]) write_backs++;
         m_valid[i] = 1'b1;
         m_dirty[i] = 1'b0;
         m_tag[i]   = t;
      end
      if (e.op == op_write) begin
         m_dirty[i] = 1'b1;
         if (e.size_word) shadow[w] = e.wdata;
         else shadow[w][8*b +: 8] = e.wdata[7:0];
      end
      value = e.size_word ? shadow[w] : {24'b0, shadow[w][8*b +: 8]};
   endtask

   task automatic model_flush();
      for (int i = 0; i < cache_pkg::cache_lines; i++) begin
         if (m_valid[i] && m_dirty[i]) write_backs++;
      end
      m_valid = '0;
      m_dirty = '0;
   endtask

   task automatic cpu_access(input entry_t e, output cache_pkg::word_t value);
      req.valid     = 1'b1;
      req.write     = e.op == op_write;
      req.size_word = e.size_word;
      req.addr      = e.addr;
      req.wdata     = e.wdata;
      do @(negedge clock); while (!ready);                   // ready settles by mid-cycle
      value = rdata;
      @(posedge clock);
      #1 req.valid = 1'b0;
   endtask

   task automatic reg_access(input logic write, input logic [1:0] offset,
                             input cache_pkg::word_t data, output cache_pkg::word_t value);
      reg_m.cyc      = 1'b1;
      reg_m.stb      = 1'b1;
      reg_m.we       = write;
      reg_m.adr      = '0;
      reg_m.adr[3:2] = offset;
      reg_m.dat      = data;
      do @(negedge clock); while (!reg_s.ack);
      value = reg_s.dat;
      @(posedge clock);
      #1;
      reg_m.cyc = 1'b0;
      reg_m.stb = 1'b0;
      reg_m.we  = 1'b0;
   endtask

   task automatic apply_entry(input entry_t e);
      cache_pkg::word_t actual;
      cache_pkg::word_t expected;
      case (e.op)
         op_read, op_write: begin
            model_access(e, expected);
            cpu_access(e, actual);
            if (e.op == op_read) check_value("rdata", actual, e.has_exp ? e.exp : expected);
         end
         op_reg_read: begin
            reg_access(1'b0, e.addr[3:2], '0, actual);
            case (e.addr[3:2])
               2'd1:    expected = hits;
               2'd2:    expected = misses;
               2'd3:    expected = write_backs;
               default: expected = e.exp;
            endcase
            check_value("reg_wb_out.dat", actual, e.has_exp ? e.exp : expected);
         end
         op_reg_write: begin
            reg_access(1'b1, e.addr[3:2], e.wdata, actual);
            if (e.addr[3:2] == 2'd0 && e.wdata[0]) model_flush();
         end
         default: begin
            do reg_access(1'b0, 2'd0, '0, actual); while (actual[1]);  // poll busy
         end
      endcase
   endtask

   task automatic build_table();
      add_entry(op_reg_read, 1'b1, 12'h004, '0, 1'b1, 32'd0);
      add_entry(op_reg_read, 1'b1, 12'h008, '0, 1'b1, 32'd0);
      add_entry(op_reg_read, 1'b1, 12'h00c, '0, 1'b1, 32'd0);
      add_entry(op_reg_read, 1'b1, 12'h000, '0, 1'b1, 32'd0);
      add_entry(op_read, 1'b1, 12'h010, '0, 1'b1, 32'hC0DE0004);
      add_entry(op_read, 1'b1, 12'h014, '0, 1'b0, '0);
      add_entry(op_reg_read, 1'b1, 12'h004, '0, 1'b0, '0);
      add_entry(op_reg_read, 1'b1, 12'h008, '0, 1'b0, '0);
      add_entry(op_write, 1'b1, 12'h040, 32'h11223344, 1'b0, '0);
      add_entry(op_write, 1'b0, 12'h041, 32'h000000AA, 1'b0, '0);
      add_entry(op_write, 1'b0, 12'h047, 32'h0000005B, 1'b0, '0);
      add_entry(op_read, 1'b1, 12'h040, '0, 1'b1, 32'h1122AA44);
      add_entry(op_read, 1'b1, 12'h044, '0, 1'b0, '0);
      add_entry(op_read, 1'b0, 12'h042, '0, 1'b0, '0);
      add_entry(op_read, 1'b1, 12'h440, '0, 1'b0, '0);       // evicts the dirty line at index 4
      add_entry(op_read, 1'b1, 12'h040, '0, 1'b1, 32'h1122AA44);
      add_entry(op_reg_read, 1'b1, 12'h00c, '0, 1'b0, '0);
      add_random(48);
      add_entry(op_reg_read, 1'b1, 12'h004, '0, 1'b0, '0);
      add_entry(op_reg_read, 1'b1, 12'h008, '0, 1'b0, '0);
      add_entry(op_reg_read, 1'b1, 12'h00c, '0, 1'b0, '0);
      add_entry(op_reg_write, 1'b1, 12'h000, 32'd1, 1'b0, '0);
      add_entry(op_reg_read, 1'b1, 12'h000, '0, 1'b1, 32'd2);
      add_entry(op_wait_idle, 1'b1, 12'h000, '0, 1'b0, '0);
      add_entry(op_reg_read, 1'b1, 12'h00c, '0, 1'b0, '0);
      add_entry(op_read, 1'b1, 12'h040, '0, 1'b0, '0);
      add_entry(op_read, 1'b1, 12'h104, '0, 1'b0, '0);
      add_entry(op_read, 1'b0, 12'h219, '0, 1'b0, '0);
      add_entry(op_read, 1'b1, 12'h37c, '0, 1'b0, '0);
      add_entry(op_read, 1'b0, 12'h063, '0, 1'b0, '0);
      add_entry(op_reg_read, 1'b1, 12'h004, '0, 1'b0, '0);
      add_entry(op_reg_read, 1'b1, 12'h008, '0, 1'b0, '0);
      add_entry(op_reg_read, 1'b1, 12'h00c, '0, 1'b0, '0);
   endtask

   initial begin
      clock       = 1'b0;
      arst_n      = 1'b0;
      req         = '0;
      reg_m       = '0;
      lfsr_state  = 32'd77971;
      hits        = 0;
      misses      = 0;
      write_backs = 0;
      m_valid     = '0;
      m_dirty     = '0;
      for (int w = 0; w < cache_pkg::mem_words; w++) begin
         shadow[w] = 32'hC0DE0000 + w;
      end
      build_table();
      limit_cycles = 40 * stimulus.size() + 2000;
      repeat (5) @(posedge clock);
      #1 arst_n = 1'b1;
      check_value("ready", cache_pkg::word_t'(ready), 32'd1);
      foreach (stimulus[k]) apply_entry(stimulus[k]);
      $display("TB PASSED");
      $finish;
   end

   initial begin
      wait (limit_cycles != 0);
      repeat (limit_cycles) @(posedge clock);
      $display("timeout: the DUT stopped answering before the stimulus table was done");
      $display("TB FAILED");
      $fatal(1, "watchdog expired");
   end

endmodule

/* verilog.f */
rtl/cache_pkg.sv
rtl/cache_core.sv
rtl/wb_line_master.sv
rtl/line_memory.sv
rtl/cache_regs.sv
rtl/cache_top.sv
tests/cache_properties.sv
tests/cache_tb.sv

/* run.sh */
#!/usr/bin/env bash
# builds the cache testbench with Verilator, runs it and checks the log
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
   --top-module cache_tb -f verilog.f -o cache_sim

./obj_dir/cache_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "TB PASSED" sim.log; then
   echo "simulation passed"
else
   echo "simulation failed"
   exit 1
fi
